/* Bender.yml */
package:
  name: fmb_tester

sources:
  # design
  - files:
      - source/fmb_tester_pkg.sv
      - source/burst_cmd_if.sv
      - source/ddr_reset_sequencer.sv
      - source/memory_test_ctrl.sv
      - source/axi_burst_master.sv
      - source/fmb_tester_top.sv
  # testbench
  - target: simulation
    files:
      - verification/axi_mem_model.sv
      - verification/tb_fmb_tester.sv

/* source/axi_burst_master.sv */
module axi_burst_master (
	input  logic iSCLK,
	input  logic qLocked,
	burst_cmd_if.master cmd,
	// write address
	output logic o_awvalid,
	input  logic i_awready,
	output fmb_tester_pkg::axi_addr_t o_awaddr,
	// write data
	output logic o_wvalid,
	input  logic i_wready,
	output fmb_tester_pkg::axi_data_t o_wdata,
	output logic o_wlast,
	// write response
	input  logic i_bvalid,
	output logic o_bready,
	input  logic [1:0] i_bresp,
	// read address
	output logic o_arvalid,
	input  logic i_arready,
	output fmb_tester_pkg::axi_addr_t o_araddr,
	// read data
	input  logic i_rvalid,
	output logic o_rready,
	input  fmb_tester_pkg::axi_data_t i_rdata,
	input  logic i_rlast,
	input  logic [1:0] i_rresp
);

	typedef enum logic [2:0] {S_IDLE, S_AW, S_W, S_B, S_AR, S_R} mst_state_t;

	mst_state_t state;
	logic [fmb_tester_pkg::BURST_IDX_W-1:0] idx_r;
	logic [fmb_tester_pkg::BEAT_W-1:0] beat;
	logic last_beat;
	logic mism_r;
	logic rerr_r;
	logic done_r;
	fmb_tester_pkg::axi_addr_t burst_addr;
	fmb_tester_pkg::axi_data_t exp_word;

	// burst base = idx * 16 beats * 32 bytes
	assign burst_addr = fmb_tester_pkg::axi_addr_t'(idx_r) *
		(fmb_tester_pkg::BEATS_PER_BURST * fmb_tester_pkg::BYTES_PER_BEAT);
	// global beat number selects the pattern, shared by write and compare
	assign exp_word = fmb_tester_pkg::pattern_word({idx_r, beat});
	assign last_beat = (beat == fmb_tester_pkg::BEATS_PER_BURST - 1);

	// --------------------
	// burst fsm
	// --------------------
	always_ff @(posedge iSCLK or negedge qLocked)
	begin
		if (!qLocked)
		begin
			state <= S_IDLE;
			idx_r <= '0;
			beat <= '0;
			mism_r <= 1'b0;
			rerr_r <= 1'b0;
			done_r <= 1'b0;
		end
		else
		begin
			done_r <= 1'b0;
			case (state)
				S_IDLE:
					if (cmd.req)
					begin
						idx_r <= cmd.burst_idx;
						beat <= '0;
						mism_r <= 1'b0;
						rerr_r <= 1'b0;
						state <= cmd.is_write ? S_AW : S_AR;
					end
				// wvalid waits for the aw handshake
				S_AW:
					if (i_awready)
						state <= S_W;
				S_W:
					if (i_wready)
					begin
						if (last_beat)
							state <= S_B;
						else
							beat <= beat + 1'b1;
					end
				S_B:
					if (i_bvalid)
					begin
						rerr_r <= rerr_r | (i_bresp != 2'b00);
						done_r <= 1'b1;
						state <= S_IDLE;
					end
				S_AR:
					if (i_arready)
						state <= S_R;
				S_R:
					if (i_rvalid)
					begin
						// rlast off its expected beat also counts as a mismatch
						mism_r <= mism_r | (i_rdata != exp_word) | (i_rlast != last_beat);
						rerr_r <= rerr_r | (i_rresp != 2'b00);
						beat <= beat + 1'b1;
						if (i_rlast)
						begin
							done_r <= 1'b1;
							state <= S_IDLE;
						end
					end
				default:
					state <= S_IDLE;
			endcase
		end
	end

	// channel controls, payload stays put until the handshake
	assign o_awvalid = (state == S_AW);
	assign o_awaddr = burst_addr;
	assign o_wvalid = (state == S_W);
	assign o_wdata = exp_word;
	assign o_wlast = (state == S_W) && last_beat;
	assign o_bready = (state == S_B);
	assign o_arvalid = (state == S_AR);
	assign o_araddr = burst_addr;
	assign o_rready = (state == S_R);

	assign cmd.done = done_r;
	assign cmd.mismatch = mism_r;
	assign cmd.resp_err = rerr_r;

endmodule

/* source/burst_cmd_if.sv */
// burst command path between test controller and axi master
// all signals synchronous to iSCLK
interface burst_cmd_if;

	// request side, one strobe per burst
	logic req;
	logic is_write;
	logic [fmb_tester_pkg::BURST_IDX_W-1:0] burst_idx;

	// completion side
	logic done;
	// both levels qualified by done
	logic mismatch;
	logic resp_err;

	modport ctrl (
		output req, is_write, burst_idx,
		input  done, mismatch, resp_err
	);

	modport master (
		input  req, is_write, burst_idx,
		output done, mismatch, resp_err
	);

endinterface

/* source/ddr_reset_sequencer.sv */
module ddr_reset_sequencer (
	input  logic iSCLK,
	input  logic qLocked,
	input  logic i_ddr_cfg_done,
	output logic o_ddr_cfg_reset,
	output logic o_ddr_cfg_start,
	output logic o_ddr_axi_rstn,
	output logic o_cfg_ready
);

	typedef enum logic [1:0] {S_RESET, S_DELAY, S_START, S_READY} seq_state_t;

	seq_state_t state;
	// one counter shared by reset and delay phases
	logic [fmb_tester_pkg::SEQ_CNT_W-1:0] cnt;
	logic [1:0] rst_sync;
	logic [1:0] done_sync;

	// --------------------
	// synchronizers
	// --------------------
	always_ff @(posedge iSCLK or negedge qLocked)
	begin
		if (!qLocked)
		begin
			rst_sync <= '0;
			done_sync <= '0;
		end
		else
		begin
			rst_sync <= {rst_sync[0], 1'b1};
			// cfg_done comes from the hard ip calibration domain
			done_sync <= {done_sync[0], i_ddr_cfg_done};
		end
	end

	// --------------------
	// phase fsm
	// --------------------
	always_ff @(posedge iSCLK or negedge qLocked)
	begin
		if (!qLocked)
		begin
			state <= S_RESET;
			cnt <= '0;
		end
		else
		begin
			case (state)
				S_RESET:
				begin
					// counter runs from release, exit needs synced release too
					if (rst_sync[1] && cnt == fmb_tester_pkg::CFG_RESET_CYCLES - 1)
					begin
						state <= S_DELAY;
						cnt <= '0;
					end
					else
						cnt <= cnt + 1'b1;
				end
				S_DELAY:
				begin
					if (cnt == fmb_tester_pkg::START_DELAY_CYCLES - 1)
						state <= S_START;
					else
						cnt <= cnt + 1'b1;
				end
				// hold start until calibration reports done
				S_START:
					if (done_sync[1])
						state <= S_READY;
				default:
					state <= S_READY;
			endcase
		end
	end

	// outputs decoded straight from the state register
	assign o_ddr_cfg_reset = (state == S_RESET);
	assign o_ddr_cfg_start = (state == S_START);
	assign o_ddr_axi_rstn = (state == S_READY);
	assign o_cfg_ready = (state == S_READY);

endmodule

/* source/fmb_tester_pkg.sv */
package fmb_tester_pkg;

	// --------------------
	// axi port geometry
	// --------------------
	localparam int AXI_DATA_W = 256;
	localparam int AXI_ADDR_W = 33;
	typedef logic [AXI_DATA_W-1:0] axi_data_t;
	typedef logic [AXI_ADDR_W-1:0] axi_addr_t;

	// checked lane is one x16 device word
	localparam int LANE_W = 16;
	localparam int LANES = AXI_DATA_W / LANE_W;

	// --------------------
	// test region
	// --------------------
	localparam int BEATS_PER_BURST = 16;
	localparam int BYTES_PER_BEAT = 32;
	localparam int BEAT_W = 4;
	localparam int TEST_BURSTS = 16;
	localparam int BURST_IDX_W = 4;
	localparam logic [LANE_W-1:0] PATTERN_KEY = 16'hA5C3;

	// controller config sequence timing
	localparam int CFG_RESET_CYCLES = 16;
	localparam int START_DELAY_CYCLES = 200;
	localparam int SEQ_CNT_W = 8;

	// lane k of beat n = (n*16 + k) ^ key, low 16 bits
	function automatic axi_data_t pattern_word(input int unsigned beat_num);
		axi_data_t word;
		logic [31:0] lane_val;
		for (int k = 0; k < LANES; k++)
		begin
			lane_val = beat_num * LANES + k;
			word[k*LANE_W +: LANE_W] = lane_val[LANE_W-1:0] ^ PATTERN_KEY;
		end
		return word;
	endfunction

endpackage

/* source/fmb_tester_top.sv */
module fmb_tester_top (
	input  logic iSCLK,
	// board reset sources
	input  logic i_pb_sw0,
	input  logic i_pll_bl1_locked,
	input  logic i_pll_tl2_locked,
	// controller configuration
	input  logic i_ddr_cfg_done,
	output logic o_ddr_cfg_reset,
	output logic o_ddr_cfg_start,
	output logic o_ddr_axi_rstn,
	// axi port 0
	output logic o_awvalid,
	input  logic i_awready,
	output fmb_tester_pkg::axi_addr_t o_awaddr,
	output logic o_wvalid,
	input  logic i_wready,
	output fmb_tester_pkg::axi_data_t o_wdata,
	output logic o_wlast,
	input  logic i_bvalid,
	output logic o_bready,
	input  logic [1:0] i_bresp,
	output logic o_arvalid,
	input  logic i_arready,
	output fmb_tester_pkg::axi_addr_t o_araddr,
	input  logic i_rvalid,
	output logic o_rready,
	input  fmb_tester_pkg::axi_data_t i_rdata,
	input  logic i_rlast,
	input  logic [1:0] i_rresp,
	// bit 0 is LED2, bit 5 is LED7
	output logic [5:0] o_led
);

	logic qLocked;
	logic cfg_ready;
	logic test_run;
	logic test_done;
	logic test_fail;

	// --------------------
	// system reset
	// --------------------
	// low while sw0 pressed or either pll unlocked
	assign qLocked = i_pb_sw0 & i_pll_bl1_locked & i_pll_tl2_locked;

	ddr_reset_sequencer u_seq (
		.iSCLK           (iSCLK),
		.qLocked         (qLocked),
		.i_ddr_cfg_done  (i_ddr_cfg_done),
		.o_ddr_cfg_reset (o_ddr_cfg_reset),
		.o_ddr_cfg_start (o_ddr_cfg_start),
		.o_ddr_axi_rstn  (o_ddr_axi_rstn),
		.o_cfg_ready     (cfg_ready)
	);

	// --------------------
	// memory check
	// --------------------
	burst_cmd_if cmd_if ();

	memory_test_ctrl u_ctrl (
		.iSCLK       (iSCLK),
		.qLocked     (qLocked),
		.i_cfg_ready (cfg_ready),
		.cmd         (cmd_if.ctrl),
		.o_test_run  (test_run),
		.o_test_done (test_done),
		.o_test_fail (test_fail)
	);

	// axi ports keep the same names through the hierarchy
	axi_burst_master u_mst (
		.iSCLK     (iSCLK),
		.qLocked   (qLocked),
		.cmd       (cmd_if.master),
		.o_awvalid, .i_awready, .o_awaddr,
		.o_wvalid, .i_wready, .o_wdata, .o_wlast,
		.i_bvalid, .o_bready, .i_bresp,
		.o_arvalid, .i_arready, .o_araddr,
		.i_rvalid, .o_rready, .i_rdata, .i_rlast, .i_rresp
	);

	// --------------------
	// status leds
	// --------------------
	assign o_led = {test_done, test_fail, test_run, cfg_ready, o_ddr_cfg_start, qLocked};

endmodule

/* source/memory_test_ctrl.sv */
module memory_test_ctrl (
	input  logic iSCLK,
	input  logic qLocked,
	input  logic i_cfg_ready,
	burst_cmd_if.ctrl cmd,
	output logic o_test_run,
	output logic o_test_done,
	output logic o_test_fail
);

	logic req_r;
	// low during write pass, high during read-back pass
	logic rd_phase;
	logic [fmb_tester_pkg::BURST_IDX_W-1:0] idx;
	logic last_burst;

	assign last_burst = rd_phase && (idx == fmb_tester_pkg::TEST_BURSTS - 1);

	// --------------------
	// command sequencing
	// --------------------
	always_ff @(posedge iSCLK or negedge qLocked)
	begin
		if (!qLocked)
		begin
			req_r <= 1'b0;
			rd_phase <= 1'b0;
			idx <= '0;
			o_test_run <= 1'b0;
			o_test_done <= 1'b0;
			o_test_fail <= 1'b0;
		end
		else
		begin
			req_r <= 1'b0;
			// single pass per reset, done blocks a restart
			if (i_cfg_ready && !o_test_run && !o_test_done)
			begin
				o_test_run <= 1'b1;
				req_r <= 1'b1;
			end
			else if (o_test_run && cmd.done)
			begin
				// sticky fail
				if (cmd.mismatch || cmd.resp_err)
					o_test_fail <= 1'b1;
				if (last_burst)
				begin
					o_test_run <= 1'b0;
					o_test_done <= 1'b1;
				end
				else
				begin
					// next burst issued only after previous done
					req_r <= 1'b1;
					idx <= idx + 1'b1;
					// index wraps to 0 at end of write pass
					if (idx == fmb_tester_pkg::TEST_BURSTS - 1)
						rd_phase <= 1'b1;
				end
			end
		end
	end

	assign cmd.req = req_r;
	assign cmd.is_write = ~rd_phase;
	assign cmd.burst_idx = idx;

endmodule

/* sources.f */
source/fmb_tester_pkg.sv
source/burst_cmd_if.sv
source/ddr_reset_sequencer.sv
source/memory_test_ctrl.sv
source/axi_burst_master.sv
source/fmb_tester_top.sv
verification/axi_mem_model.sv
verification/tb_fmb_tester.sv

/* verification/axi_mem_model.sv */
module axi_mem_model (
	input  logic iSCLK,
	input  logic qLocked,
	// knobs, negative index disables corruption or error
	input  logic i_stall_en,
	input  int i_corrupt_beat,
	input  int i_werr_burst,
	// write address
	input  logic i_awvalid,
	output logic o_awready,
	input  fmb_tester_pkg::axi_addr_t i_awaddr,
	// write data
	input  logic i_wvalid,
	output logic o_wready,
	input  fmb_tester_pkg::axi_data_t i_wdata,
	input  logic i_wlast,
	// write response
	output logic o_bvalid,
	input  logic i_bready,
	output logic [1:0] o_bresp,
	// read address
	input  logic i_arvalid,
	output logic o_arready,
	input  fmb_tester_pkg::axi_addr_t i_araddr,
	// read data
	output logic o_rvalid,
	input  logic i_rready,
	output fmb_tester_pkg::axi_data_t o_rdata,
	output logic o_rlast,
	output logic [1:0] o_rresp
);

	// sparse store, one entry per 32-byte beat
	fmb_tester_pkg::axi_data_t mem [int];
	// write log in arrival order
	fmb_tester_pkg::axi_addr_t wr_addr [$];
	fmb_tester_pkg::axi_data_t wr_data [$];
	logic wr_last [$];

	// handshakes seen at the last rising edge
	logic aw_hs;
	logic w_hs;
	logic b_hs;
	logic ar_hs;
	logic r_hs;
	fmb_tester_pkg::axi_addr_t aw_addr_s;
	fmb_tester_pkg::axi_addr_t ar_addr_s;
	fmb_tester_pkg::axi_data_t w_data_s;
	logic w_last_s;

	// burst state, in beat units
	int w_base;
	int w_beat;
	int r_base;
	int r_beat;
	logic r_act;

	function automatic logic rand_ready();
		return !i_stall_en || ($urandom_range(0, 1) == 1);
	endfunction

	// missing entries read as zero, one bit flipped on the chosen beat
	function automatic fmb_tester_pkg::axi_data_t read_beat(input int n);
		fmb_tester_pkg::axi_data_t d;
		d = mem.exists(n) ? mem[n] : '0;
		if (n == i_corrupt_beat)
			d[3] = ~d[3];
		return d;
	endfunction

	initial
	begin
		o_awready = 1'b0;
		o_wready = 1'b0;
		o_bvalid = 1'b0;
		o_bresp = 2'b00;
		o_arready = 1'b0;
		o_rvalid = 1'b0;
		o_rdata = '0;
		o_rlast = 1'b0;
		o_rresp = 2'b00;
		r_act = 1'b0;
	end

	// --------------------
	// handshake capture
	// --------------------
	always @(posedge iSCLK)
	begin
		aw_hs <= i_awvalid && o_awready;
		aw_addr_s <= i_awaddr;
		w_hs <= i_wvalid && o_wready;
		w_data_s <= i_wdata;
		w_last_s <= i_wlast;
		b_hs <= o_bvalid && i_bready;
		ar_hs <= i_arvalid && o_arready;
		ar_addr_s <= i_araddr;
		r_hs <= o_rvalid && i_rready;
	end

	// --------------------
	// slave response, driven on falling edge
	// --------------------
	always @(negedge iSCLK)
	begin
		if (!qLocked)
		begin
			mem.delete();
			wr_addr.delete();
			wr_data.delete();
			wr_last.delete();
			o_bvalid = 1'b0;
			o_rvalid = 1'b0;
			o_rlast = 1'b0;
			r_act = 1'b0;
		end
		else
		begin
			if (aw_hs)
			begin
				w_base = int'(aw_addr_s >> 5);
				w_beat = 0;
			end
			if (b_hs)
				o_bvalid = 1'b0;
			if (w_hs)
			begin
				mem[w_base + w_beat] = w_data_s;
				wr_addr.push_back(fmb_tester_pkg::axi_addr_t'((w_base + w_beat) * 32));
				wr_data.push_back(w_data_s);
				wr_last.push_back(w_last_s);
				w_beat++;
				// response only after wlast
				if (w_last_s)
				begin
					o_bvalid = 1'b1;
					o_bresp = (w_base / 16 == i_werr_burst) ? 2'b10 : 2'b00;
				end
			end
			if (ar_hs)
			begin
				r_base = int'(ar_addr_s >> 5);
				r_beat = 0;
				r_act = 1'b1;
			end
			if (r_hs)
			begin
				r_beat++;
				if (r_beat == fmb_tester_pkg::BEATS_PER_BURST)
					r_act = 1'b0;
			end
			// rvalid holds until accepted
			if (!o_rvalid || r_hs)
				o_rvalid = r_act && rand_ready();
			if (r_act)
			begin
				o_rdata = read_beat(r_base + r_beat);
				o_rlast = (r_beat == fmb_tester_pkg::BEATS_PER_BURST - 1);
			end
			o_awready = rand_ready();
			o_wready = rand_ready();
			o_arready = rand_ready();
		end
	end

endmodule

/* verification/tb_fmb_tester.sv */
module tb_fmb_tester;

	logic iSCLK;
	logic i_pb_sw0;
	logic i_pll_bl1_locked;
	logic i_pll_tl2_locked;
	logic i_ddr_cfg_done;
	logic o_ddr_cfg_reset;
	logic o_ddr_cfg_start;
	logic o_ddr_axi_rstn;
	logic o_awvalid;
	logic i_awready;
	fmb_tester_pkg::axi_addr_t o_awaddr;
	logic o_wvalid;
	logic i_wready;
	fmb_tester_pkg::axi_data_t o_wdata;
	logic o_wlast;
	logic i_bvalid;
	logic o_bready;
	logic [1:0] i_bresp;
	logic o_arvalid;
	logic i_arready;
	fmb_tester_pkg::axi_addr_t o_araddr;
	logic i_rvalid;
	logic o_rready;
	fmb_tester_pkg::axi_data_t i_rdata;
	logic i_rlast;
	logic [1:0] i_rresp;
	logic [5:0] o_led;

	logic qLocked;
	// memory model knobs
	logic stall_en;
	int corrupt_beat;
	int werr_burst;
	int resp_wait;
	int n_err;
	int n_fail;

	assign qLocked = i_pb_sw0 & i_pll_bl1_locked & i_pll_tl2_locked;

	fmb_tester_top dut (.*);

	axi_mem_model u_mem (
		.iSCLK          (iSCLK),
		.qLocked        (qLocked),
		.i_stall_en     (stall_en),
		.i_corrupt_beat (corrupt_beat),
		.i_werr_burst   (werr_burst),
		.i_awvalid      (o_awvalid),
		.o_awready      (i_awready),
		.i_awaddr       (o_awaddr),
		.i_wvalid       (o_wvalid),
		.o_wready       (i_wready),
		.i_wdata        (o_wdata),
		.i_wlast        (o_wlast),
		.o_bvalid       (i_bvalid),
		.i_bready       (o_bready),
		.o_bresp        (i_bresp),
		.i_arvalid      (o_arvalid),
		.o_arready      (i_arready),
		.i_araddr       (o_araddr),
		.o_rvalid       (i_rvalid),
		.i_rready       (o_rready),
		.o_rdata        (i_rdata),
		.o_rlast        (i_rlast),
		.o_rresp        (i_rresp)
	);

	always #2 iSCLK = ~iSCLK;

	// calibration responder, done follows start after 5 to 20 cycles
	always @(negedge iSCLK)
	begin
		if (!qLocked)
		begin
			i_ddr_cfg_done = 1'b0;
			resp_wait = -1;
		end
		else if (o_ddr_cfg_start && !i_ddr_cfg_done)
		begin
			if (resp_wait < 0)
				resp_wait = $urandom_range(4, 19);
			else if (resp_wait == 0)
				i_ddr_cfg_done = 1'b1;
			else
				resp_wait--;
		end
	end

	// --------------------
	// compare tasks
	// --------------------
	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("** Error: %s = %h, expected %h", name, got, exp);
			n_err++;
		end
	endtask

	task automatic check_beat(input string name, input fmb_tester_pkg::axi_data_t got,
		input fmb_tester_pkg::axi_data_t exp);
		if (got !== exp)
		begin
			$display("** Error: %s = %h, expected %h", name, got, exp);
			n_err++;
		end
	endtask

	task automatic check_addr(input string name, input fmb_tester_pkg::axi_addr_t got,
		input fmb_tester_pkg::axi_addr_t exp);
		if (got !== exp)
		begin
			$display("** Error: %s = %h, expected %h", name, got, exp);
			n_err++;
		end
	endtask

	task automatic check_led(input logic [5:0] got, input logic [5:0] exp);
		if (got !== exp)
		begin
			$display("** Error: o_led = %h, expected %h", got, exp);
			n_err++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
		begin
			$display("** Error: %s = %h, expected %h", name, got, exp);
			n_err++;
		end
	endtask

	// independent copy of the fill rule, lane k of beat n
	function automatic fmb_tester_pkg::axi_data_t expected_beat(input int n);
		fmb_tester_pkg::axi_data_t d;
		logic [15:0] lane;
		for (int k = 0; k < 16; k++)
		begin
			lane = 16'(n * 16 + k);
			d[k*16 +: 16] = lane ^ 16'hA5C3;
		end
		return d;
	endfunction

	// --------------------
	// helpers
	// --------------------
	// all three reset sources low for two cycles
	task automatic apply_reset(input logic stall, input int corrupt, input int werr);
		@(negedge iSCLK);
		i_pb_sw0 = 1'b0;
		i_pll_bl1_locked = 1'b0;
		i_pll_tl2_locked = 1'b0;
		stall_en = stall;
		corrupt_beat = corrupt;
		werr_burst = werr;
		repeat (2) @(negedge iSCLK);
		i_pb_sw0 = 1'b1;
		i_pll_bl1_locked = 1'b1;
		i_pll_tl2_locked = 1'b1;
	endtask

	task automatic wait_test_done(input string what);
		int n;
		n = 0;
		while (!o_test_done_seen() && n < 20000)
		begin
			@(negedge iSCLK);
			n++;
		end
		if (!o_test_done_seen())
		begin
			$display("timeout: test never reported done during %s", what);
			n_fail++;
		end
	endtask

	function automatic logic o_test_done_seen();
		return o_led[5];
	endfunction

	// address, data and wlast of every write beat, then the stored copy
	task automatic check_write_log();
		int total;
		total = fmb_tester_pkg::TEST_BURSTS * fmb_tester_pkg::BEATS_PER_BURST;
		check_count("write beat count", u_mem.wr_data.size(), total);
		if (u_mem.wr_data.size() == total)
		begin
			for (int i = 0; i < total; i++)
			begin
				check_addr($sformatf("awaddr beat %0d", i), u_mem.wr_addr[i],
					fmb_tester_pkg::axi_addr_t'(i * 32));
				check_beat($sformatf("wdata beat %0d", i), u_mem.wr_data[i], expected_beat(i));
				check_bit($sformatf("wlast beat %0d", i), u_mem.wr_last[i], (i % 16) == 15);
				check_beat($sformatf("stored beat %0d", i), u_mem.mem[i], expected_beat(i));
			end
		end
	endtask

	// --------------------
	// directed tests
	// --------------------
	task automatic test_config_sequence();
		int n;
		apply_reset(1'b0, -1, -1);
		n = 0;
		while (o_ddr_cfg_reset && n < 100)
		begin
			n++;
			@(negedge iSCLK);
		end
		check_count("cfg_reset cycles", n, fmb_tester_pkg::CFG_RESET_CYCLES);
		// start delay, only the reset led lit
		n = 0;
		while (!o_ddr_cfg_start && n < 400)
		begin
			check_led(o_led, 6'b000001);
			n++;
			@(negedge iSCLK);
		end
		check_count("cfg_start delay cycles", n, fmb_tester_pkg::START_DELAY_CYCLES);
		// axi reset held until calibration done
		n = 0;
		while (!i_ddr_cfg_done && n < 40)
		begin
			check_bit("o_ddr_axi_rstn", o_ddr_axi_rstn, 1'b0);
			check_led(o_led, 6'b000011);
			n++;
			@(negedge iSCLK);
		end
		if (!i_ddr_cfg_done)
		begin
			$display("timeout: responder never raised cfg_done");
			n_fail++;
		end
		n = 0;
		while (!o_ddr_axi_rstn && n < 10)
		begin
			n++;
			@(negedge iSCLK);
		end
		if (!o_ddr_axi_rstn)
		begin
			$display("timeout: axi reset was not released after cfg_done");
			n_fail++;
		end
		check_led(o_led, 6'b000101);
	endtask

	task automatic test_clean_run();
		apply_reset(1'b0, -1, -1);
		wait_test_done("clean run");
		check_write_log();
		check_bit("test_fail", o_led[4], 1'b0);
		check_bit("test_run", o_led[3], 1'b0);
		check_led(o_led, 6'b100101);
	endtask

	task automatic test_back_pressure();
		apply_reset(1'b1, -1, -1);
		wait_test_done("back-pressure run");
		check_write_log();
		check_led(o_led, 6'b100101);
	endtask

	task automatic test_read_corruption();
		apply_reset(1'b0, 37, -1);
		wait_test_done("read corruption run");
		check_bit("test_done", o_led[5], 1'b1);
		check_bit("test_fail", o_led[4], 1'b1);
		check_led(o_led, 6'b110101);
	endtask

	// slverr on burst 5 write response
	task automatic test_response_error();
		apply_reset(1'b0, -1, 5);
		wait_test_done("response error run");
		check_bit("test_fail", o_led[4], 1'b1);
	endtask

	initial
	begin
		void'($urandom(8));
		iSCLK = 1'b0;
		i_pb_sw0 = 1'b0;
		i_pll_bl1_locked = 1'b0;
		i_pll_tl2_locked = 1'b0;
		i_ddr_cfg_done = 1'b0;
		stall_en = 1'b0;
		corrupt_beat = -1;
		werr_burst = -1;
		n_err = 0;
		n_fail = 0;
		test_config_sequence();
		test_clean_run();
		test_back_pressure();
		test_read_corruption();
		test_response_error();
		$display("errors: %0d wrong values, %0d other failures", n_err, n_fail);
		if (n_err == 0 && n_fail == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule
